// ==== src/cache_pkg.sv ====
// cache package
// shared widths, data types and control enums of the two-way cache controller
package cache_pkg;

	localparam int addr_bits = 32;      // word address
	localparam int word_bits = 32;
	localparam int words_per_line = 4;
	localparam int offset_bits = 2;     // word select in a line

	typedef logic [word_bits-1:0] word_t;
	typedef logic [addr_bits-1:0] addr_t;
	typedef logic [words_per_line*word_bits-1:0] line_t; // word 0 sits in the low bits
	typedef logic [offset_bits-1:0] offset_t;

	// controller states; being outside idle is what stalls the processor
	typedef enum logic [1:0] {
		idle,
		lookup,
		write_back,
		refill
	} cache_state_t;

	typedef enum logic {
		burst_read,  // memory to cache
		burst_write  // dirty victim to memory
	} burst_op_t;

endpackage

// ==== src/cache_intf.sv ====
// cache internal buses
// tag lookup, line access and memory burst connections between the controller blocks

interface lookup_if #(parameter int index_bits = 10);
	localparam int tag_bits = cache_pkg::addr_bits - index_bits - cache_pkg::offset_bits;

	logic [index_bits-1:0] index;
	logic [tag_bits-1:0]   tag;
	logic                  upd;          // commit one access
	logic                  upd_way;
	logic                  set_dirty;
	logic                  fill;         // upd installs tag as a new valid line
	logic                  hit;
	logic                  hit_way;
	logic                  victim_way;
	logic                  victim_dirty;
	logic [tag_bits-1:0]   victim_tag;

	modport ctrl (output index, tag, upd, upd_way, set_dirty, fill,
		input hit, hit_way, victim_way, victim_dirty, victim_tag);
	modport array (input index, tag, upd, upd_way, set_dirty, fill,
		output hit, hit_way, victim_way, victim_dirty, victim_tag);
endinterface

interface line_if #(parameter int index_bits = 10);
	logic [index_bits-1:0] index;
	logic                  way;
	cache_pkg::offset_t    offset;
	logic                  wr_word;
	cache_pkg::word_t      wdata;
	logic                  fill_line;
	cache_pkg::line_t      fill_data;
	cache_pkg::word_t      rdata;       // word picked by offset
	cache_pkg::line_t      victim_data; // whole line of way

	modport ctrl (output index, way, offset, wr_word, wdata, fill_line, fill_data,
		input rdata, victim_data);
	modport array (input index, way, offset, wr_word, wdata, fill_line, fill_data,
		output rdata, victim_data);
endinterface

interface burst_if;
	logic                 start;
	cache_pkg::burst_op_t op;
	cache_pkg::addr_t     base;     // line base, offset zero
	cache_pkg::line_t     out_line;
	cache_pkg::line_t     in_line;
	logic                 done;

	modport ctrl (output start, op, base, out_line, input in_line, done);
	modport unit (input start, op, base, out_line, output in_line, done);
endinterface

// ==== src/cache_tag_array.sv ====
// cache tag array
// per set valid, dirty and tag for two ways plus one lru bit, with hit and victim logic
module cache_tag_array #(
	parameter int index_bits = 10
) (
	input logic clk,
	input logic reset,
	lookup_if.array lookup
);
	localparam int tag_bits = cache_pkg::addr_bits - index_bits - cache_pkg::offset_bits;
	localparam int sets = 1 << index_bits;

	logic                valid [2][sets];
	logic                dirty [2][sets];
	logic [tag_bits-1:0] tags  [2][sets];
	logic                lru   [sets]; // least recently used way

	logic hit0;
	logic hit1;
	logic victim;

	assign hit0 = valid[0][lookup.index] && (tags[0][lookup.index] == lookup.tag);
	assign hit1 = valid[1][lookup.index] && (tags[1][lookup.index] == lookup.tag);

	assign lookup.hit = hit0 | hit1;
	assign lookup.hit_way = hit1;

	// an empty way wins over the lru way, way 0 first
	assign victim = !valid[0][lookup.index] ? 1'b0 :
		!valid[1][lookup.index] ? 1'b1 : lru[lookup.index];

	assign lookup.victim_way = victim;
	assign lookup.victim_dirty = valid[victim][lookup.index] & dirty[victim][lookup.index];
	assign lookup.victim_tag = tags[victim][lookup.index];

	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			for (int s = 0; s < sets; s++) begin
				valid[0][s] <= 1'b0;
				valid[1][s] <= 1'b0;
				dirty[0][s] <= 1'b0;
				dirty[1][s] <= 1'b0;
				tags[0][s] <= '0;
				tags[1][s] <= '0;
				lru[s] <= 1'b0;
			end
		end else if (lookup.upd) begin
			lru[lookup.index] <= ~lookup.upd_way; // other way is now the older one
			if (lookup.fill) begin
				valid[lookup.upd_way][lookup.index] <= 1'b1;
				tags[lookup.upd_way][lookup.index] <= lookup.tag;
				dirty[lookup.upd_way][lookup.index] <= 1'b0; // fresh copy of memory
			end else if (lookup.set_dirty) begin
				dirty[lookup.upd_way][lookup.index] <= 1'b1;
			end
		end
	end

endmodule

// ==== src/cache_data_array.sv ====
// cache data array
// four word lines for both ways, word read and write, whole line fill
module cache_data_array #(
	parameter int index_bits = 10
) (
	input logic clk,
	line_if.array line
);
	localparam int sets = 1 << index_bits;

	cache_pkg::line_t lines [2][sets];
	cache_pkg::line_t sel_line;

	// reads are combinational
	assign sel_line = lines[line.way][line.index];
	assign line.victim_data = sel_line;
	assign line.rdata = sel_line[line.offset*cache_pkg::word_bits +: cache_pkg::word_bits];

	always_ff @(posedge clk) begin
		if (line.fill_line) begin
			lines[line.way][line.index] <= line.fill_data; // refill from memory
		end else if (line.wr_word) begin
			lines[line.way][line.index][line.offset*cache_pkg::word_bits +: cache_pkg::word_bits]
				<= line.wdata;
		end
	end

endmodule

// ==== src/mem_burst_unit.sv ====
// memory burst unit
// moves one cache line to or from main memory as four word beats, paced by ready_mem
module mem_burst_unit (
	input  logic             clk,
	input  logic             reset,
	burst_if.unit            burst,
	input  logic             ready_mem,
	input  cache_pkg::word_t rdata_mem,
	output logic             read_mem,
	output logic             write_mem,
	output cache_pkg::addr_t addr_mem,
	output cache_pkg::word_t wdata_mem
);
	localparam int line_bits = cache_pkg::words_per_line * cache_pkg::word_bits;

	logic                 busy;
	logic [1:0]           beat;  // beats done so far
	logic                 done_q;
	cache_pkg::burst_op_t op_q;
	cache_pkg::addr_t     base_q;
	cache_pkg::line_t     line_q; // outgoing words shift out, incoming shift in

	logic accept;
	logic step;

	assign accept = burst.start && !busy;
	assign step = busy && ready_mem;

	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			busy <= 1'b0;
			beat <= 2'd0;
			done_q <= 1'b0;
			op_q <= cache_pkg::burst_read;
		end else begin
			done_q <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				beat <= 2'd0;
				op_q <= burst.op;
			end else if (step) begin
				beat <= beat + 2'd1;
				if (beat == 2'd3) begin // fourth beat ends the burst
					busy <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			base_q <= burst.base;
			line_q <= burst.out_line;
		end else if (step) begin
			if (op_q == cache_pkg::burst_write)
				line_q <= line_q >> cache_pkg::word_bits;
			else
				line_q <= {rdata_mem, line_q[line_bits-1:cache_pkg::word_bits]};
		end
	end

	assign read_mem = busy && (op_q == cache_pkg::burst_read);
	assign write_mem = busy && (op_q == cache_pkg::burst_write);
	assign addr_mem = base_q;
	assign wdata_mem = line_q[cache_pkg::word_bits-1:0]; // lowest word is the next beat

	assign burst.in_line = line_q;
	assign burst.done = done_q;

endmodule

// ==== src/cache_fsm.sv ====
// cache control FSM
// latches the processor access, resolves hits and sequences write back and refill
module cache_fsm #(
	parameter int index_bits = 10
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             read_up,
	input  logic             write_up,
	input  cache_pkg::addr_t addr_up,
	input  cache_pkg::word_t wdata_up,
	output cache_pkg::word_t rdata_up,
	output logic             stall_up,
	lookup_if.ctrl           lookup,
	line_if.ctrl             line,
	burst_if.ctrl            burst
);
	localparam int tag_bits = cache_pkg::addr_bits - index_bits - cache_pkg::offset_bits;

	cache_pkg::cache_state_t state;
	cache_pkg::cache_state_t state_next;

	cache_pkg::addr_t addr_q;
	cache_pkg::word_t wdata_q;
	logic             is_write;
	logic             way_sel;
	logic             wb_sel;
	logic [index_bits-1:0] index;
	logic [tag_bits-1:0]   tag;

	always_ff @(posedge clk, negedge reset) begin
		if (!reset) begin
			state <= cache_pkg::idle;
			is_write <= 1'b0;
			rdata_up <= '0;
		end else begin
			state <= state_next;
			if (state == cache_pkg::idle && (read_up || write_up))
				is_write <= write_up;
			if (state == cache_pkg::lookup && lookup.hit && !is_write)
				rdata_up <= line.rdata; // held until the next read completes
		end
	end

	// access latch, loaded with the strobe
	always_ff @(posedge clk) begin
		if (state == cache_pkg::idle && (read_up || write_up)) begin
			addr_q <= addr_up;
			wdata_q <= wdata_up;
		end
	end

	assign index = addr_q[cache_pkg::offset_bits +: index_bits];
	assign tag = addr_q[cache_pkg::addr_bits-1 -: tag_bits];

	// the hit way on a hit, otherwise the line being replaced
	assign way_sel = lookup.hit ? lookup.hit_way : lookup.victim_way;
	assign wb_sel = (state == cache_pkg::lookup) && lookup.victim_dirty;

	assign lookup.index = index;
	assign lookup.tag = tag;
	assign lookup.upd_way = way_sel;

	assign line.index = index;
	assign line.way = way_sel;
	assign line.offset = addr_q[cache_pkg::offset_bits-1:0];
	assign line.wdata = wdata_q;
	assign line.fill_data = burst.in_line;

	assign burst.op = wb_sel ? cache_pkg::burst_write : cache_pkg::burst_read;
	assign burst.base = wb_sel ? {lookup.victim_tag, index, cache_pkg::offset_bits'(0)} :
		{tag, index, cache_pkg::offset_bits'(0)};
	assign burst.out_line = line.victim_data;

	assign stall_up = (state != cache_pkg::idle);

	always_comb begin
		state_next = state;
		lookup.upd = 1'b0;
		lookup.set_dirty = 1'b0;
		lookup.fill = 1'b0;
		line.wr_word = 1'b0;
		line.fill_line = 1'b0;
		burst.start = 1'b0;
		case (state)
			cache_pkg::idle: begin
				if (read_up || write_up)
					state_next = cache_pkg::lookup;
			end
			cache_pkg::lookup: begin
				if (lookup.hit) begin
					lookup.upd = 1'b1;
					lookup.set_dirty = is_write;
					line.wr_word = is_write;
					state_next = cache_pkg::idle;
				end else begin
					burst.start = 1'b1; // write back first if the victim is dirty
					state_next = lookup.victim_dirty ? cache_pkg::write_back : cache_pkg::refill;
				end
			end
			cache_pkg::write_back: begin
				if (burst.done) begin
					burst.start = 1'b1; // victim is out, fetch the new line
					state_next = cache_pkg::refill;
				end
			end
			cache_pkg::refill: begin
				if (burst.done) begin
					lookup.upd = 1'b1;
					lookup.fill = 1'b1;
					line.fill_line = 1'b1;
					state_next = cache_pkg::lookup; // replays the access as a hit
				end
			end
			default: state_next = cache_pkg::idle;
		endcase
	end

endmodule

// ==== src/cache_controller.sv ====
// cache controller top
// two-way write-back cache between processor and word-wide main memory
module cache_controller #(
	parameter int index_bits = 10
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             read_up,
	input  logic             write_up,
	input  cache_pkg::addr_t addr_up,
	input  cache_pkg::word_t wdata_up,
	output cache_pkg::word_t rdata_up,
	output logic             stall_up,
	input  logic             ready_mem,
	input  cache_pkg::word_t rdata_mem,
	output logic             read_mem,
	output logic             write_mem,
	output cache_pkg::addr_t addr_mem,
	output cache_pkg::word_t wdata_mem
);

	lookup_if #(.index_bits(index_bits)) lookup_bus ();
	line_if #(.index_bits(index_bits)) line_bus ();
	burst_if burst_bus ();

	cache_fsm #(.index_bits(index_bits)) cache_fsm_i (
		.clk      (clk),
		.reset    (reset),
		.read_up  (read_up),
		.write_up (write_up),
		.addr_up  (addr_up),
		.wdata_up (wdata_up),
		.rdata_up (rdata_up),
		.stall_up (stall_up),
		.lookup   (lookup_bus.ctrl),
		.line     (line_bus.ctrl),
		.burst    (burst_bus.ctrl)
	);

	cache_tag_array #(.index_bits(index_bits)) cache_tag_array_i (
		.clk    (clk),
		.reset  (reset),
		.lookup (lookup_bus.array)
	);

	cache_data_array #(.index_bits(index_bits)) cache_data_array_i (
		.clk  (clk),
		.line (line_bus.array)
	);

	mem_burst_unit mem_burst_unit_i (
		.clk       (clk),
		.reset     (reset),
		.burst     (burst_bus.unit),
		.ready_mem (ready_mem),
		.rdata_mem (rdata_mem),
		.read_mem  (read_mem),
		.write_mem (write_mem),
		.addr_mem  (addr_mem),
		.wdata_mem (wdata_mem)
	);

endmodule

// ==== dv/cache_checker.sv ====
// cache checker
// reference model of the cache and memory, compares every access and every memory beat
module cache_checker #(
	parameter int index_bits = 2
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             read_up,
	input  logic             write_up,
	input  cache_pkg::addr_t addr_up,
	input  cache_pkg::word_t wdata_up,
	input  cache_pkg::word_t rdata_up,
	input  logic             stall_up,
	input  logic             ready_mem,
	input  logic             read_mem,
	input  logic             write_mem,
	input  cache_pkg::addr_t addr_mem,
	input  cache_pkg::word_t wdata_mem,
	input  logic [2:0]       test_id,
	input  logic             run_done,
	output int               error_count,
	output logic             finished
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int sets = 1 << index_bits;
	localparam int tag_bits = cache_pkg::addr_bits - index_bits - cache_pkg::offset_bits;

	cache_pkg::word_t ref_mem [cache_pkg::addr_t]; // last written word, else inverted address
	logic                ref_valid [2][sets] = '{default: 1'b0};
	logic                ref_dirty [2][sets] = '{default: 1'b0};
	logic [tag_bits-1:0] ref_tag [2][sets] = '{default: '0};
	logic                ref_lru [sets] = '{default: 1'b0};

	// memory beats still to come, oldest first
	logic             exp_write_q [$];
	cache_pkg::addr_t exp_base_q [$];
	cache_pkg::word_t exp_data_q [$];

	logic             pending = 1'b0;
	logic             pending_read = 1'b0;
	logic             exp_hit = 1'b0;
	logic             reset_checked = 1'b0;
	logic             report_done = 1'b0;
	cache_pkg::word_t exp_rdata = '0;
	int               stall_cycles = 0;
	int               errors = 0;
	int               test_errors = 0;
	int               tests_run = 0;
	int               tests_failed = 0;
	logic [2:0]       last_test = 3'd0;

	assign error_count = errors;
	assign finished = report_done;

	function automatic cache_pkg::word_t mem_word(input cache_pkg::addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : ~a;
	endfunction

	function automatic void queue_beat(input logic wr, input cache_pkg::addr_t base,
			input cache_pkg::word_t d);
		exp_write_q.push_back(wr);
		exp_base_q.push_back(base);
		exp_data_q.push_back(d);
	endfunction

	// expected read value of one access; queues the bursts it causes and updates the model
	function automatic cache_pkg::word_t predict_access(input logic wr,
			input cache_pkg::addr_t a, input cache_pkg::word_t d);
		logic [index_bits-1:0] idx;
		logic [tag_bits-1:0]   tg;
		cache_pkg::addr_t      base;
		cache_pkg::addr_t      vbase;
		logic                  way;
		int                    k;
		idx = a[cache_pkg::offset_bits +: index_bits];
		tg = a[cache_pkg::addr_bits-1 -: tag_bits];
		base = {a[cache_pkg::addr_bits-1:cache_pkg::offset_bits], 2'b00};
		exp_hit = 1'b1;
		if (ref_valid[0][idx] && ref_tag[0][idx] == tg) begin
			way = 1'b0;
		end else if (ref_valid[1][idx] && ref_tag[1][idx] == tg) begin
			way = 1'b1;
		end else begin
			exp_hit = 1'b0;
			way = !ref_valid[0][idx] ? 1'b0 : !ref_valid[1][idx] ? 1'b1 : ref_lru[idx];
			if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
				vbase = {ref_tag[way][idx], idx, 2'b00}; // dirty victim goes out first
				for (k = 0; k < 4; k++)
					queue_beat(1'b1, vbase, mem_word(vbase + cache_pkg::addr_t'(k)));
			end
			for (k = 0; k < 4; k++)
				queue_beat(1'b0, base, '0);
			ref_valid[way][idx] = 1'b1;
			ref_tag[way][idx] = tg;
			ref_dirty[way][idx] = 1'b0;
		end
		ref_lru[idx] = ~way;
		if (wr) begin
			ref_dirty[way][idx] = 1'b1;
			ref_mem[a] = d;
		end
		return mem_word(a);
	endfunction

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1: return "reset";
			3'd2: return "cold read miss";
			3'd3: return "write then read";
			3'd4: return "eviction";
			default: return "random mix";
		endcase
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("error at time %0t: %s expected %h, actual %h", $time, name, exp_v, act_v);
		errors++;
		test_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("at time %0t: %s", $time, what);
		errors++;
		test_errors++;
	endtask

	task automatic close_test();
		if (last_test != 3'd0) begin
			tests_run++;
			if (test_errors != 0)
				tests_failed++;
			$display("test %0d %s: %s, %0d errors", last_test, test_name(last_test),
				(test_errors == 0) ? "ok" : "failed", test_errors);
		end
		test_errors = 0;
	endtask

	task automatic check_beat();
		logic             exp_wr;
		cache_pkg::addr_t exp_base;
		cache_pkg::word_t exp_data;
		if (exp_write_q.size() == 0) begin
			report_problem("memory beat while no burst was expected");
		end else begin
			exp_wr = exp_write_q.pop_front();
			exp_base = exp_base_q.pop_front();
			exp_data = exp_data_q.pop_front();
			if (write_mem !== exp_wr)
				report_value("write_mem", 32'(exp_wr), 32'(write_mem));
			if (addr_mem !== exp_base)
				report_value("addr_mem", exp_base, addr_mem);
			if (exp_wr && wdata_mem !== exp_data)
				report_value("wdata_mem", exp_data, wdata_mem);
		end
	endtask

	task automatic finish_access();
		if (exp_write_q.size() != 0) begin
			report_problem($sformatf("access ended with %0d memory beats missing",
				exp_write_q.size()));
			exp_write_q.delete();
			exp_base_q.delete();
			exp_data_q.delete();
		end
		if (pending_read && rdata_up !== exp_rdata)
			report_value("rdata_up", exp_rdata, rdata_up);
		if (exp_hit && stall_cycles != 1)
			report_problem($sformatf("hit stalled for %0d cycles instead of one", stall_cycles));
		pending = 1'b0;
	endtask

	// all sampling on the rising edge, where the DUT outputs are settled
	always @(posedge clk) begin
		if (reset) begin
			if (test_id != last_test) begin
				close_test();
				last_test = test_id;
			end
			if (!reset_checked) begin
				if (stall_up !== 1'b0)
					report_value("stall_up", 32'd0, 32'(stall_up));
				if (read_mem !== 1'b0)
					report_value("read_mem", 32'd0, 32'(read_mem));
				if (write_mem !== 1'b0)
					report_value("write_mem", 32'd0, 32'(write_mem));
				if (rdata_up !== '0)
					report_value("rdata_up", 32'd0, rdata_up);
				reset_checked = 1'b1;
			end
			if ((read_mem || write_mem) && ready_mem)
				check_beat();
			if (pending && stall_up)
				stall_cycles++;
			else if (pending)
				finish_access();
			if (!stall_up && (read_up || write_up)) begin
				pending = 1'b1;
				pending_read = read_up;
				stall_cycles = 0;
				exp_rdata = predict_access(write_up, addr_up, wdata_up);
			end
			if (run_done && !report_done) begin
				close_test();
				$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
				report_done = 1'b1;
			end
		end
	end

endmodule

// ==== dv/tb_cache.sv ====
// cache controller testbench
// clock, reset, word-wide memory model and the directed and random access sequences
module tb_cache;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int index_bits = 2;
	localparam int random_ops = 200;
	localparam int op_count = 10 + random_ops; // directed accesses and reset included
	localparam int cycle_limit = 40 * op_count;

	logic             clk;
	logic             reset;
	logic             read_up;
	logic             write_up;
	cache_pkg::addr_t addr_up;
	cache_pkg::word_t wdata_up;
	cache_pkg::word_t rdata_up;
	logic             stall_up;
	logic             ready_mem = 1'b0;
	cache_pkg::word_t rdata_mem = '0;
	logic             read_mem;
	logic             write_mem;
	cache_pkg::addr_t addr_mem;
	cache_pkg::word_t wdata_mem;

	logic [2:0] test_id;
	logic       run_done;
	int         error_count;
	logic       finished;

	cache_pkg::word_t mem [cache_pkg::addr_t]; // untouched words read as the inverted address
	logic [1:0]  mem_beat = 2'd0;
	logic [31:0] ready_seed = 32'h7fa;
	logic [31:0] stim_seed = 32'h7fa;
	int          cycles = 0;

	cache_controller #(.index_bits(index_bits)) cache_controller_i (
		.clk       (clk),
		.reset     (reset),
		.read_up   (read_up),
		.write_up  (write_up),
		.addr_up   (addr_up),
		.wdata_up  (wdata_up),
		.rdata_up  (rdata_up),
		.stall_up  (stall_up),
		.ready_mem (ready_mem),
		.rdata_mem (rdata_mem),
		.read_mem  (read_mem),
		.write_mem (write_mem),
		.addr_mem  (addr_mem),
		.wdata_mem (wdata_mem)
	);

	cache_checker #(.index_bits(index_bits)) cache_checker_i (
		.clk         (clk),
		.reset       (reset),
		.read_up     (read_up),
		.write_up    (write_up),
		.addr_up     (addr_up),
		.wdata_up    (wdata_up),
		.rdata_up    (rdata_up),
		.stall_up    (stall_up),
		.ready_mem   (ready_mem),
		.read_mem    (read_mem),
		.write_mem   (write_mem),
		.addr_mem    (addr_mem),
		.wdata_mem   (wdata_mem),
		.test_id     (test_id),
		.run_done    (run_done),
		.error_count (error_count),
		.finished    (finished)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cache_pkg::word_t mem_word(input cache_pkg::addr_t a);
		return mem.exists(a) ? mem[a] : ~a;
	endfunction

	// one word per rising edge with ready_mem high
	always @(posedge clk) begin
		if (!(read_mem || write_mem)) begin
			mem_beat <= 2'd0;
		end else if (ready_mem) begin
			if (write_mem)
				mem[addr_mem + 32'(mem_beat)] = wdata_mem;
			mem_beat <= mem_beat + 2'd1;
		end
	end

	always @(negedge clk) begin
		ready_seed = next_rand(ready_seed);
		ready_mem <= ready_seed[17:16] != 2'b00; // ready about three cycles in four
		rdata_mem <= read_mem ? mem_word(addr_mem + 32'(mem_beat)) : '0;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// starts on a falling edge with stall_up low, returns once the stall is over
	task automatic run_access(input logic wr, input cache_pkg::addr_t a,
			input cache_pkg::word_t d);
		read_up = !wr;
		write_up = wr;
		addr_up = a;
		wdata_up = d;
		@(negedge clk);
		read_up = 1'b0;
		write_up = 1'b0;
		while (stall_up)
			@(negedge clk);
	endtask

	task automatic start_test(input logic [2:0] id);
		repeat (2) @(negedge clk);
		test_id = id;
	endtask

	task automatic random_mix();
		cache_pkg::addr_t a;
		cache_pkg::word_t d;
		logic             wr;
		int               n;
		for (n = 0; n < random_ops; n++) begin
			stim_seed = next_rand(stim_seed);
			a = 32'h0000_0100 + 32'(stim_seed[21:16]); // 16 lines, four per set
			wr = stim_seed[26];
			stim_seed = next_rand(stim_seed);
			d = stim_seed;
			run_access(wr, a, d);
		end
	endtask

	initial begin
		reset = 1'b0;
		read_up = 1'b0;
		write_up = 1'b0;
		addr_up = '0;
		wdata_up = '0;
		test_id = 3'd1; // reset values are checked on the first edge after release
		run_done = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		start_test(3'd2);
		run_access(1'b0, 32'h0000_0009, '0);
		start_test(3'd3);
		run_access(1'b1, 32'h0000_000a, 32'h1234_5678);
		run_access(1'b0, 32'h0000_000a, '0);
		start_test(3'd4);
		run_access(1'b0, 32'h0000_0204, '0); // set 1, way 0
		run_access(1'b1, 32'h0000_0216, 32'hcafe_0001); // set 1, way 1 dirty
		run_access(1'b0, 32'h0000_0225, '0); // clean victim, no write back
		run_access(1'b0, 32'h0000_0207, '0); // dirty victim written back first
		start_test(3'd5);
		random_mix();
		repeat (2) @(negedge clk);
		run_done = 1'b1;
		while (!finished)
			@(negedge clk);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
src/cache_pkg.sv
src/cache_intf.sv
src/cache_tag_array.sv
src/cache_data_array.sv
src/mem_burst_unit.sv
src/cache_fsm.sv
src/cache_controller.sv
dv/cache_checker.sv
dv/tb_cache.sv

// ==== run.sh ====
#!/bin/sh
# build the cache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_cache \
	-Mdir obj_dir -o sim_cache -f flist.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_cache > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
